/* mm_ctrl_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module mm_ctrl_assertions #(
	parameter int PE_ROWS = 32,
	parameter int PE_COLS = 32
) (
	input wire logic               CLK,
	input wire logic               RSTn,
	input wire logic               stall,
	input wire logic               computing,
	input wire logic               flushing,
	input wire logic               finished,
	input wire logic [PE_ROWS-1:0] opnd1_push,
	input wire logic [PE_ROWS-1:0] opnd1_pop,
	input wire logic [PE_COLS-1:0] opnd2_push,
	input wire logic [PE_COLS-1:0] opnd2_pop
);

	int fails = 0;	// Read by the testbench top

	// One phase level at a time
	phase_excl: assert property (@(posedge CLK) disable iff (!RSTn)
		!(computing && flushing))
		else begin
			fails++;
			$error("computing and flushing are high together");
		end

	// Pulse only stretched by a stall
	fin_pulse: assert property (@(posedge CLK) disable iff (!RSTn)
		(finished && !stall) |=> !finished)
		else begin
			fails++;
			$error("finished stayed high without a stall");
		end

	// FIFO enables only while computing
	quiet_enables: assert property (@(posedge CLK) disable iff (!RSTn)
		!computing |-> (opnd1_push == '0 && opnd1_pop == '0
			&& opnd2_push == '0 && opnd2_pop == '0))
		else begin
			fails++;
			$error("FIFO enable active outside compute");
		end

endmodule

bind mm_ctrl_top mm_ctrl_assertions #(
	.PE_ROWS (PE_ROWS),
	.PE_COLS (PE_COLS)
) u_assert (
	.CLK        (CLK),
	.RSTn       (RSTn),
	.stall      (stall),
	.computing  (computing),
	.flushing   (flushing),
	.finished   (finished),
	.opnd1_push (opnd1_push),
	.opnd1_pop  (opnd1_pop),
	.opnd2_push (opnd2_push),
	.opnd2_pop  (opnd2_pop)
);

`default_nettype wire

/* mm_ctrl_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module mm_ctrl_checker import mm_ctrl_pkg::*; #(
	parameter int PE_ROWS = 32,
	parameter int PE_COLS = 32
) (
	input wire logic               CLK,
	input wire logic               RSTn,
	input wire logic               start,
	input wire logic               stall,
	input wire size_t              m_size,
	input wire size_t              k_size,
	input wire size_t              n_size,
	input wire sram_addr_t         opnd1_addr,
	input wire sram_addr_t         opnd2_addr,
	input wire sram_addr_t         out_addr,
	input wire logic [PE_ROWS-1:0] opnd1_push,
	input wire logic [PE_ROWS-1:0] opnd1_pop,
	input wire logic [PE_COLS-1:0] opnd2_push,
	input wire logic [PE_COLS-1:0] opnd2_pop,
	input wire logic               computing,
	input wire logic               flushing,
	input wire logic               finished
);

	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_COMP  = 2'd1;
	localparam logic [1:0] ST_FLUSH = 2'd2;

	// Sequencer state plus every registered output
	typedef struct packed {
		logic [1:0]         ph;
		int                 cnt;
		int                 r;
		int                 c;
		int                 m;
		int                 k;
		int                 n;
		int                 rt;		// Tile rows
		int                 ct;		// Tile columns
		sram_addr_t         o1;
		sram_addr_t         o2;
		sram_addr_t         oa;
		logic [PE_ROWS-1:0] push1;
		logic [PE_ROWS-1:0] pop1;
		logic [PE_COLS-1:0] push2;
		logic [PE_COLS-1:0] pop2;
		logic               comp;
		logic               flush;
		logic               fin;
	} model_t;

	model_t exp_q;
	logic   primed = 1'b0;	// Set by the first reset edge
	int     errors = 0;
	int     checks = 0;

	function automatic int lanes(int total, int idx, int pe);
		int left;
		left = total - idx * pe;
		return (left < pe) ? left : pe;	// Edge tile keeps the rest
	endfunction

	// One clock edge of the controller
	function automatic model_t ref_cycle(model_t s, logic rst_n, logic go, logic hold,
			int m, int k, int n);
		model_t nx;
		int     ar;
		int     ac;
		int     t;
		logic   last;
		nx = s;
		if (!rst_n)
			return model_t'(0);
		if (hold)
			return s;	// Everything frozen
		ar   = lanes(s.m, s.r, PE_ROWS);
		ac   = lanes(s.n, s.c, PE_COLS);
		t    = s.cnt;
		last = (s.ph == ST_FLUSH) && (t == ar - 1) && (s.r == s.rt - 1) && (s.c == s.ct - 1);
		nx.comp  = (s.ph == ST_COMP);
		nx.flush = (s.ph == ST_FLUSH);
		nx.fin   = last;
		for (int i = 0; i < PE_ROWS; i++) begin
			nx.push1[i] = nx.comp && (t < s.k) && (i < ar);
			nx.pop1[i]  = nx.comp && (i < ar) && (t >= i) && (t <= s.k - 1 + i);	// Skew
		end
		for (int i = 0; i < PE_COLS; i++) begin
			nx.push2[i] = nx.comp && (t < s.k) && (i < ac);
			nx.pop2[i]  = nx.comp && (i < ac) && (t >= i) && (t <= s.k - 1 + i);
		end
		if (nx.comp && t < s.k) begin
			nx.o1 = sram_addr_t'(t * s.rt + s.r);	// Column-major
			nx.o2 = sram_addr_t'(t * s.ct + s.c);	// Row-major
		end
		if (nx.flush)
			nx.oa = sram_addr_t'((s.r * PE_ROWS + t) * s.ct + s.c);
		case (s.ph)
			ST_IDLE: begin
				if (go) begin
					nx.ph  = ST_COMP;
					nx.cnt = 0;
					nx.m   = m;
					nx.k   = k;
					nx.n   = n;
					nx.rt  = (m + PE_ROWS - 1) / PE_ROWS;
					nx.ct  = (n + PE_COLS - 1) / PE_COLS;
					nx.r   = 0;
					nx.c   = 0;
				end
			end
			ST_COMP: begin
				if (t == s.k + ar + ac - 2) begin
					nx.ph  = ST_FLUSH;
					nx.cnt = 0;
				end else begin
					nx.cnt = t + 1;
				end
			end
			ST_FLUSH: begin
				if (t < ar - 1) begin
					nx.cnt = t + 1;
				end else if (last) begin
					nx.ph  = ST_IDLE;
					nx.cnt = 0;
				end else begin	// Columns first
					nx.ph  = ST_COMP;
					nx.cnt = 0;
					nx.c   = (s.c == s.ct - 1) ? 0 : s.c + 1;
					nx.r   = (s.c == s.ct - 1) ? s.r + 1 : s.r;
				end
			end
			default: nx.ph = ST_IDLE;
		endcase
		return nx;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	// Inputs settle on the falling edge, so the rising edge sees them stable
	always @(posedge CLK) begin
		exp_q <= ref_cycle(exp_q, RSTn, start, stall, int'(m_size), int'(k_size),
			int'(n_size));
		if (!RSTn)
			primed <= 1'b1;
	end

	// Outputs compared mid-cycle
	always @(negedge CLK) begin
		if (primed) begin
			check_val("opnd1_addr", 32'(exp_q.o1), 32'(opnd1_addr));
			check_val("opnd2_addr", 32'(exp_q.o2), 32'(opnd2_addr));
			check_val("out_addr", 32'(exp_q.oa), 32'(out_addr));
			check_val("opnd1_push", 32'(exp_q.push1), 32'(opnd1_push));
			check_val("opnd1_pop", 32'(exp_q.pop1), 32'(opnd1_pop));
			check_val("opnd2_push", 32'(exp_q.push2), 32'(opnd2_push));
			check_val("opnd2_pop", 32'(exp_q.pop2), 32'(opnd2_pop));
			check_val("computing", 32'(exp_q.comp), 32'(computing));
			check_val("flushing", 32'(exp_q.flush), 32'(flushing));
			check_val("finished", 32'(exp_q.fin), 32'(finished));
		end
	end

endmodule

`default_nettype wire

/* mm_ctrl_pkg.sv */
`default_nettype none

package mm_ctrl_pkg;

	// Data path widths
	localparam int SIZE_W = 9;	// Dimensions up to 511
	localparam int ADDR_W = 10;	// SRAM row address
	localparam int CNT_W  = 11;	// Holds K plus both lane skews
	localparam int LANE_W = 6;	// 1 to 32 active lanes

	typedef logic [SIZE_W-1:0] size_t;		// One matrix dimension
	typedef logic [SIZE_W-1:0] tile_id_t;	// Tile index or tile count
	typedef logic [ADDR_W-1:0] sram_addr_t;	// Operand or output row
	typedef logic [CNT_W-1:0]  phase_cnt_t;	// Compute or flush index
	typedef logic [LANE_W-1:0] lane_cnt_t;	// Active rows or columns of a tile

	// Controller phase
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_COMPUTE,
		PH_FLUSH
	} phase_e;

	// One controller cycle as seen by the second stages
	typedef struct packed {
		phase_e     phase;
		phase_cnt_t count;		// Index inside the phase
		size_t      k_size;
		tile_id_t   tile_row;
		tile_id_t   tile_col;
		lane_cnt_t  act_rows;
		lane_cnt_t  act_cols;
		tile_id_t   stride1;	// Tile rows, RT
		tile_id_t   stride2;	// Tile columns, CT
		logic       last;		// Final flush step of the job
	} step_t;

endpackage

`default_nettype wire

/* mm_ctrl_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mm_ctrl_top import mm_ctrl_pkg::*; #(
	parameter int PE_ROWS      = 32,	// PE array rows, power of two
	parameter int PE_COLS      = 32,	// PE array columns, power of two
	parameter int PE_ROWS_LOG2 = 5,
	parameter int PE_COLS_LOG2 = 5
) (
	input  wire logic          CLK,
	input  wire logic          RSTn,
	input  wire logic          start,
	input  wire logic          stall,
	input  wire size_t         m_size,	// Operand 1 is M x K
	input  wire size_t         k_size,
	input  wire size_t         n_size,	// Operand 2 is K x N
	output sram_addr_t         opnd1_addr,
	output sram_addr_t         opnd2_addr,
	output sram_addr_t         out_addr,
	output logic [PE_ROWS-1:0] opnd1_push,
	output logic [PE_ROWS-1:0] opnd1_pop,
	output logic [PE_COLS-1:0] opnd2_push,
	output logic [PE_COLS-1:0] opnd2_pop,
	output logic               computing,
	output logic               flushing,
	output logic               finished
);

	step_t step;	// Stage 1 to stage 2

	// Job latch, FSM, tile walk
	tile_sequencer #(
		.PE_ROWS      (PE_ROWS),
		.PE_COLS      (PE_COLS),
		.PE_ROWS_LOG2 (PE_ROWS_LOG2),
		.PE_COLS_LOG2 (PE_COLS_LOG2)
	) u_sequencer (
		.CLK    (CLK),
		.RSTn   (RSTn),
		.start  (start),
		.stall  (stall),
		.m_size (m_size),
		.k_size (k_size),
		.n_size (n_size),
		.step   (step)
	);

	// Operand SRAM reads and FIFO enables
	operand_issue #(
		.PE_ROWS (PE_ROWS),
		.PE_COLS (PE_COLS)
	) u_operand (
		.CLK        (CLK),
		.RSTn       (RSTn),
		.stall      (stall),
		.step       (step),
		.opnd1_addr (opnd1_addr),
		.opnd2_addr (opnd2_addr),
		.opnd1_push (opnd1_push),
		.opnd1_pop  (opnd1_pop),
		.opnd2_push (opnd2_push),
		.opnd2_pop  (opnd2_pop),
		.computing  (computing)
	);

	// Output SRAM writes and job end
	result_drain #(
		.PE_ROWS_LOG2 (PE_ROWS_LOG2)
	) u_result (
		.CLK      (CLK),
		.RSTn     (RSTn),
		.stall    (stall),
		.step     (step),
		.out_addr (out_addr),
		.flushing (flushing),
		.finished (finished)
	);

endmodule

`default_nettype wire

/* operand_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_issue import mm_ctrl_pkg::*; #(
	parameter int PE_ROWS = 32,
	parameter int PE_COLS = 32
) (
	input  wire logic         CLK,
	input  wire logic         RSTn,
	input  wire logic         stall,
	input  wire step_t        step,
	output sram_addr_t        opnd1_addr,
	output sram_addr_t        opnd2_addr,
	output logic [PE_ROWS-1:0] opnd1_push,
	output logic [PE_ROWS-1:0] opnd1_pop,
	output logic [PE_COLS-1:0] opnd2_push,
	output logic [PE_COLS-1:0] opnd2_pop,
	output logic              computing
);

	// Lanes below the active count, widest array is 32
	function automatic logic [31:0] lane_mask(lane_cnt_t act);
		logic [31:0] m;
		for (int i = 0; i < 32; i++)
			m[i] = (lane_cnt_t'(i) < act);
		return m;
	endfunction

	// Skewed pop window, lane i pops for t in [i, K-1+i]
	function automatic logic [31:0] pop_window(lane_cnt_t act, phase_cnt_t t,
			phase_cnt_t k);
		logic [31:0] w;
		for (int i = 0; i < 32; i++)
			w[i] = (lane_cnt_t'(i) < act) && (t >= phase_cnt_t'(i))
				&& (t < k + phase_cnt_t'(i));
		return w;
	endfunction

	phase_cnt_t  k_cnt;
	logic        in_compute;
	logic        feeding;		// Operand rows still being read
	logic [31:0] push1_win;
	logic [31:0] push2_win;
	logic [31:0] pop1_win;
	logic [31:0] pop2_win;

	assign k_cnt      = phase_cnt_t'(step.k_size);
	assign in_compute = (step.phase == PH_COMPUTE);
	assign feeding    = in_compute && (step.count < k_cnt);

	assign push1_win = feeding ? lane_mask(step.act_rows) : '0;
	assign push2_win = feeding ? lane_mask(step.act_cols) : '0;
	assign pop1_win  = pop_window(step.act_rows, step.count, k_cnt);
	assign pop2_win  = pop_window(step.act_cols, step.count, k_cnt);

	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			opnd1_addr <= '0;
			opnd2_addr <= '0;
			opnd1_push <= '0;
			opnd1_pop  <= '0;
			opnd2_push <= '0;
			opnd2_pop  <= '0;
			computing  <= 1'b0;
		end else if (!stall) begin
			computing  <= in_compute;
			opnd1_push <= push1_win[PE_ROWS-1:0];
			opnd2_push <= push2_win[PE_COLS-1:0];
			opnd1_pop  <= in_compute ? pop1_win[PE_ROWS-1:0] : '0;	// Quiet outside compute
			opnd2_pop  <= in_compute ? pop2_win[PE_COLS-1:0] : '0;

			// Running addresses, held once t reaches K
			if (feeding) begin
				if (step.count == '0) begin	// Tile base
					opnd1_addr <= sram_addr_t'(step.tile_row);
					opnd2_addr <= sram_addr_t'(step.tile_col);
				end else begin
					opnd1_addr <= opnd1_addr + sram_addr_t'(step.stride1);
					opnd2_addr <= opnd2_addr + sram_addr_t'(step.stride2);
				end
			end
		end
	end

endmodule

`default_nettype wire

/* result_drain.sv */
`timescale 1ns/10ps
`default_nettype none

module result_drain import mm_ctrl_pkg::*; #(
	parameter int PE_ROWS_LOG2 = 5
) (
	input  wire logic  CLK,
	input  wire logic  RSTn,
	input  wire logic  stall,
	input  wire step_t step,
	output sram_addr_t out_addr,	// Output SRAM write row
	output logic       flushing,
	output logic       finished	// One pulse per job
);

	logic       in_flush;
	sram_addr_t row_base;	// First output row of the tile, r * PE_ROWS
	sram_addr_t out_base;
	sram_addr_t out_stride;

	assign in_flush = (step.phase == PH_FLUSH);

	// Row-major output, stride is the tile column count
	assign out_stride = sram_addr_t'(step.stride2);
	assign row_base   = sram_addr_t'(step.tile_row) << PE_ROWS_LOG2;
	assign out_base   = row_base * out_stride + sram_addr_t'(step.tile_col);	// Wraps

	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			out_addr <= '0;
			flushing <= 1'b0;
			finished <= 1'b0;
		end else if (!stall) begin
			flushing <= in_flush;
			finished <= step.last;	// Lines up with the last flush output

			// One output row per flush step
			if (in_flush) begin
				if (step.count == '0)
					out_addr <= out_base;
				else
					out_addr <= out_addr + out_stride;
			end
		end
	end

endmodule

`default_nettype wire

/* sources.f */
mm_ctrl_pkg.sv
tile_sequencer.sv
operand_issue.sv
result_drain.sv
mm_ctrl_top.sv
mm_ctrl_assertions.sv
mm_ctrl_checker.sv
tb_mm_ctrl.sv

/* tb_mm_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mm_ctrl import mm_ctrl_pkg::*;;

	localparam int PE_R = 4;
	localparam int PE_C = 4;

	logic            CLK;
	logic            RSTn;
	logic            start;
	logic            stall;
	size_t           m_size;
	size_t           k_size;
	size_t           n_size;
	sram_addr_t      opnd1_addr;
	sram_addr_t      opnd2_addr;
	sram_addr_t      out_addr;
	logic [PE_R-1:0] opnd1_push;
	logic [PE_R-1:0] opnd1_pop;
	logic [PE_C-1:0] opnd2_push;
	logic [PE_C-1:0] opnd2_pop;
	logic            computing;
	logic            flushing;
	logic            finished;

	int unsigned lcg_state   = 32'd53;
	int          stall_left  = 0;
	int          limit_cycles = 0;	// Watchdog budget, 0 until jobs are built
	int          jobs_done   = 0;	// Rising edges of finished
	logic        fin_prev    = 1'b0;
	int          jm[$];
	int          jk[$];
	int          jn[$];

	mm_ctrl_top #(
		.PE_ROWS      (PE_R),
		.PE_COLS      (PE_C),
		.PE_ROWS_LOG2 (2),
		.PE_COLS_LOG2 (2)
	) uut (
		.CLK(CLK), .RSTn(RSTn), .start(start), .stall(stall),
		.m_size(m_size), .k_size(k_size), .n_size(n_size),
		.opnd1_addr(opnd1_addr), .opnd2_addr(opnd2_addr), .out_addr(out_addr),
		.opnd1_push(opnd1_push), .opnd1_pop(opnd1_pop),
		.opnd2_push(opnd2_push), .opnd2_pop(opnd2_pop),
		.computing(computing), .flushing(flushing), .finished(finished)
	);

	mm_ctrl_checker #(
		.PE_ROWS (PE_R),
		.PE_COLS (PE_C)
	) chk (
		.CLK(CLK), .RSTn(RSTn), .start(start), .stall(stall),
		.m_size(m_size), .k_size(k_size), .n_size(n_size),
		.opnd1_addr(opnd1_addr), .opnd2_addr(opnd2_addr), .out_addr(out_addr),
		.opnd1_push(opnd1_push), .opnd1_pop(opnd1_pop),
		.opnd2_push(opnd2_push), .opnd2_pop(opnd2_pop),
		.computing(computing), .flushing(flushing), .finished(finished)
	);

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;	// Upper bits are the better ones
	endfunction

	// Working cycles of one job, compute plus flush of every tile
	function automatic int job_cycles(int m, int k, int n);
		int total;
		int ar;
		int ac;
		total = 0;
		for (int r = 0; r * PE_R < m; r++) begin
			for (int c = 0; c * PE_C < n; c++) begin
				ar    = (m - r * PE_R < PE_R) ? m - r * PE_R : PE_R;
				ac    = (n - c * PE_C < PE_C) ? n - c * PE_C : PE_C;
				total = total + (k + ar + ac - 1) + ar;
			end
		end
		return total;
	endfunction

	task automatic add_job(input int m, input int k, input int n);
		jm.push_back(m);
		jk.push_back(k);
		jn.push_back(n);
	endtask

	// Noisy jobs get stall bursts and stray start pulses
	task automatic run_job(input int m, input int k, input int n, input bit noisy);
		bit seen;
		m_size = size_t'(m);
		k_size = size_t'(k);
		n_size = size_t'(n);
		start  = 1'b1;
		stall  = 1'b0;
		@(negedge CLK);
		start = 1'b0;
		seen  = 1'b0;
		while (!seen) begin
			if (finished) begin
				seen = 1'b1;
			end else begin
				if (noisy) begin
					if (stall_left > 0) begin
						stall = 1'b1;
						stall_left--;
					end else if (!stall && lcg_next() % 8 == 0) begin
						stall      = 1'b1;
						stall_left = lcg_next() % 4;	// Burst of 1 to 4
					end else begin
						stall = 1'b0;
					end
					start = (lcg_next() % 16 == 0);	// Must be ignored mid-job
					if (start) begin
						m_size = size_t'(1 + lcg_next() % 12);
						k_size = size_t'(1 + lcg_next() % 12);
						n_size = size_t'(1 + lcg_next() % 12);
					end
				end
				@(negedge CLK);
			end
		end
		start      = 1'b0;
		stall      = 1'b0;
		stall_left = 0;
		@(negedge CLK);	// Lets finished drop
	endtask

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// One count per job, a stretched pulse counts once
	always @(negedge CLK) begin
		if (finished === 1'b1 && fin_prev !== 1'b1)
			jobs_done++;
		fin_prev = finished;
	end

	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge CLK);
		$display("Timeout: the controller did not finish its jobs in time");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int budget;
		RSTn   = 1'b0;
		start  = 1'b0;
		stall  = 1'b0;
		m_size = '0;
		k_size = '0;
		n_size = '0;
		add_job(3, 4, 2);	// Single tiles
		add_job(4, 6, 4);
		add_job(10, 5, 7);	// Edge tiles both ways
		add_job(1, 1, 1);
		add_job(8, 3, 12);
		add_job(12, 2, 5);
		for (int i = 0; i < 10; i++)
			add_job(1 + lcg_next() % 12, 1 + lcg_next() % 12, 1 + lcg_next() % 12);
		budget = 0;
		foreach (jm[i])
			budget = budget + job_cycles(jm[i], jk[i], jn[i]);
		// Free cycle after every stall burst of up to four
		limit_cycles = budget * 5 + jm.size() * 10 + 200;
		repeat (10) @(negedge CLK);
		RSTn = 1'b1;
		repeat (5) @(negedge CLK);	// Idle outputs stay zero
		foreach (jm[i])
			run_job(jm[i], jk[i], jn[i], i >= 3);
		repeat (5) @(negedge CLK);
		$display("Checks %0d, check errors %0d, assertion failures %0d, jobs %0d of %0d",
			chk.checks, chk.errors, uut.u_assert.fails, jobs_done, jm.size());
		if (chk.errors == 0 && uut.u_assert.fails == 0 && jobs_done == jm.size())
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tile_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module tile_sequencer import mm_ctrl_pkg::*; #(
	parameter int PE_ROWS      = 32,
	parameter int PE_COLS      = 32,
	parameter int PE_ROWS_LOG2 = 5,
	parameter int PE_COLS_LOG2 = 5
) (
	input  wire logic  CLK,
	input  wire logic  RSTn,
	input  wire logic  start,	// Strobe, only seen in idle
	input  wire logic  stall,	// Freezes every register
	input  wire size_t m_size,
	input  wire size_t k_size,
	input  wire size_t n_size,
	output step_t      step
);

	// Number of tiles along one dimension, ceil(sz / 2**lg)
	function automatic tile_id_t tile_count(size_t sz, int lg);
		size_t mask;
		mask = size_t'((1 << lg) - 1);
		return tile_id_t'(sz >> lg) + tile_id_t'((sz & mask) != '0);
	endfunction

	// Active lanes of a tile from the rows or columns still left
	function automatic lane_cnt_t act_lanes(size_t remain, int lanes);
		if (remain >= size_t'(lanes))
			return lane_cnt_t'(lanes);
		return lane_cnt_t'(remain);	// Edge tile
	endfunction

	// FSM and counters
	phase_e     state;
	phase_cnt_t count;

	// Latched job
	size_t      m_q;
	size_t      k_q;
	size_t      n_q;
	tile_id_t   rt_q;		// Tile rows
	tile_id_t   ct_q;		// Tile columns

	// Current tile
	tile_id_t   row_q;
	tile_id_t   col_q;
	lane_cnt_t  rows_q;
	lane_cnt_t  cols_q;

	phase_cnt_t compute_end;
	logic       compute_done;
	logic       flush_done;
	logic       col_end;
	logic       tile_last;
	tile_id_t   nxt_row;
	tile_id_t   nxt_col;
	size_t      rows_left;
	size_t      cols_left;

	// Last compute index, E = K + rows + cols - 2
	assign compute_end = phase_cnt_t'(k_q) + phase_cnt_t'(rows_q)
		+ phase_cnt_t'(cols_q) - phase_cnt_t'(2);
	assign compute_done = (count == compute_end);
	assign flush_done   = (count == phase_cnt_t'(rows_q) - phase_cnt_t'(1));	// One per row

	// Columns first, then rows
	assign col_end   = (col_q == ct_q - tile_id_t'(1));
	assign tile_last = col_end && (row_q == rt_q - tile_id_t'(1));
	assign nxt_col   = col_end ? '0 : col_q + tile_id_t'(1);
	assign nxt_row   = col_end ? row_q + tile_id_t'(1) : row_q;

	// Rows and columns not yet covered by earlier tiles
	assign rows_left = m_q - (size_t'(nxt_row) << PE_ROWS_LOG2);
	assign cols_left = n_q - (size_t'(nxt_col) << PE_COLS_LOG2);

	// Job sizes, sampled with the start strobe
	always_ff @(posedge CLK) begin
		if (!stall && state == PH_IDLE && start) begin
			m_q <= m_size;
			k_q <= k_size;
			n_q <= n_size;
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			state  <= PH_IDLE;
			count  <= '0;
			rt_q   <= '0;
			ct_q   <= '0;
			row_q  <= '0;
			col_q  <= '0;
			rows_q <= '0;
			cols_q <= '0;
		end else if (!stall) begin
			unique case (state)
				PH_IDLE: begin
					if (start) begin	// First tile straight from the inputs
						state  <= PH_COMPUTE;
						count  <= '0;
						rt_q   <= tile_count(m_size, PE_ROWS_LOG2);
						ct_q   <= tile_count(n_size, PE_COLS_LOG2);
						row_q  <= '0;
						col_q  <= '0;
						rows_q <= act_lanes(m_size, PE_ROWS);
						cols_q <= act_lanes(n_size, PE_COLS);
					end
				end
				PH_COMPUTE: begin
					if (compute_done) begin
						state <= PH_FLUSH;
						count <= '0;
					end else begin
						count <= count + phase_cnt_t'(1);
					end
				end
				PH_FLUSH: begin
					if (!flush_done) begin
						count <= count + phase_cnt_t'(1);
					end else if (tile_last) begin	// Job done
						state <= PH_IDLE;
						count <= '0;
					end else begin
						// Next tile, no gap cycle
						state  <= PH_COMPUTE;
						count  <= '0;
						row_q  <= nxt_row;
						col_q  <= nxt_col;
						rows_q <= act_lanes(rows_left, PE_ROWS);
						cols_q <= act_lanes(cols_left, PE_COLS);
					end
				end
				default: begin
					state <= PH_IDLE;
					count <= '0;
				end
			endcase
		end
	end

	// Step bus for the second stages
	always_comb begin
		step.phase    = state;
		step.count    = count;
		step.k_size   = k_q;
		step.tile_row = row_q;
		step.tile_col = col_q;
		step.act_rows = rows_q;
		step.act_cols = cols_q;
		step.stride1  = rt_q;	// Operand 1 is column-major
		step.stride2  = ct_q;	// Operand 2 and output are row-major
		// Phase check first so idle never looks at unlatched sizes
		step.last     = (state == PH_FLUSH) && flush_done && tile_last;
	end

endmodule

`default_nettype wire
